//--- rtl/fp_slice_pkg.sv
// FP min/max slice shared definitions
package fp_slice_pkg;

  // ----------------------------------------------------------------------
  // Datapath geometry
  // ----------------------------------------------------------------------

  // Full slice width, holds one FP32 value or two FP16 values
  localparam int unsigned SLICE_WIDTH = 32;

  // Number of SIMD lanes, sized for the narrowest format
  localparam int unsigned NUM_LANES = 2;

  // Lane width in FP16 mode
  localparam int unsigned FP16_WIDTH = 16;

  // ----------------------------------------------------------------------
  // Formats and status
  // ----------------------------------------------------------------------

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  // IEEE exception flags, ordered {NV, DZ, OF, UF, NX}
  typedef logic [4:0] status_t;

  // Invalid operation flag position
  localparam int unsigned STATUS_NV = 4;

  // One status vector per lane, lane 0 in the low bits
  typedef status_t [NUM_LANES-1:0] lane_status_t;

  // One bit per lane, used for SIMD mask and lane activity
  typedef logic [NUM_LANES-1:0] lane_bits_t;

  // ----------------------------------------------------------------------
  // Operand word
  // ----------------------------------------------------------------------

  // Same 32 bits seen as one FP32 value or as FP16 lanes
  // fp16[0] is the low half
  typedef union packed {
    logic [SLICE_WIDTH-1:0]               fp32;
    logic [NUM_LANES-1:0][FP16_WIDTH-1:0] fp16;
  } fp_word_u;

  // ----------------------------------------------------------------------
  // Canonical quiet NaNs
  // ----------------------------------------------------------------------

  // Positive sign, all-ones exponent, only the quiet bit set
  localparam logic [SLICE_WIDTH-1:0] CANON_NAN_FP32 = 32'h7fc0_0000;
  localparam logic [FP16_WIDTH-1:0]  CANON_NAN_FP16 = 16'h7e00;

endpackage

//--- rtl/minmax_lanes.sv
// FP min/max lane datapath
`timescale 1ns/1ps

module minmax_lanes (
  input  fp_slice_pkg::fp_word_u     operands_a_i,
  input  fp_slice_pkg::fp_word_u     operands_b_i,
  input  fp_slice_pkg::fp_format_e   fmt_i,
  input  logic                       vectorial_op_i,
  input  logic                       op_mod_i,
  output fp_slice_pkg::fp_word_u     lane_result_o,
  output fp_slice_pkg::lane_status_t lane_status_o,
  output fp_slice_pkg::lane_bits_t   lane_active_o
);

  import fp_slice_pkg::*;

  // Field masks with FP16 values zero-extended in the low half
  localparam logic [SLICE_WIDTH-1:0] FP32_SIGN_MASK  = 32'h8000_0000;
  localparam logic [SLICE_WIDTH-1:0] FP32_EXP_MASK   = 32'h7f80_0000;
  localparam logic [SLICE_WIDTH-1:0] FP32_MAN_MASK   = 32'h007f_ffff;
  localparam logic [SLICE_WIDTH-1:0] FP32_QUIET_MASK = 32'h0040_0000;
  localparam logic [SLICE_WIDTH-1:0] FP16_SIGN_MASK  = 32'h0000_8000;
  localparam logic [SLICE_WIDTH-1:0] FP16_EXP_MASK   = 32'h0000_7c00;
  localparam logic [SLICE_WIDTH-1:0] FP16_MAN_MASK   = 32'h0000_03ff;
  localparam logic [SLICE_WIDTH-1:0] FP16_QUIET_MASK = 32'h0000_0200;

  // ----------------------------------------------------------------------
  // Min/max of one value pair in either format
  // ----------------------------------------------------------------------
  function automatic logic [SLICE_WIDTH-1:0] minmax_value(
    input  logic [SLICE_WIDTH-1:0] a,
    input  logic [SLICE_WIDTH-1:0] b,
    input  fp_format_e             fmt,
    input  logic                   is_max,
    output logic                   nv
  );
    logic [SLICE_WIDTH-1:0] sign_mask;
    logic [SLICE_WIDTH-1:0] exp_mask;
    logic [SLICE_WIDTH-1:0] man_mask;
    logic [SLICE_WIDTH-1:0] quiet_mask;
    logic [SLICE_WIDTH-1:0] canon_nan;
    logic [SLICE_WIDTH-1:0] a_mag;
    logic [SLICE_WIDTH-1:0] b_mag;
    logic                   a_nan;
    logic                   b_nan;
    logic                   a_neg;
    logic                   b_neg;
    logic                   a_lt_b;

    if (fmt == FP32) begin
      sign_mask  = FP32_SIGN_MASK;
      exp_mask   = FP32_EXP_MASK;
      man_mask   = FP32_MAN_MASK;
      quiet_mask = FP32_QUIET_MASK;
      canon_nan  = CANON_NAN_FP32;
    end else begin
      sign_mask  = FP16_SIGN_MASK;
      exp_mask   = FP16_EXP_MASK;
      man_mask   = FP16_MAN_MASK;
      quiet_mask = FP16_QUIET_MASK;
      canon_nan  = SLICE_WIDTH'(CANON_NAN_FP16);
    end

    // Classification
    a_nan = ((a & exp_mask) == exp_mask) && ((a & man_mask) != '0);
    b_nan = ((b & exp_mask) == exp_mask) && ((b & man_mask) != '0);
    nv    = (a_nan && ((a & quiet_mask) == '0)) || (b_nan && ((b & quiet_mask) == '0));

    // Sign-magnitude compare where negative zero orders below positive zero
    a_mag = a & (exp_mask | man_mask);
    b_mag = b & (exp_mask | man_mask);
    a_neg = (a & sign_mask) != '0;
    b_neg = (b & sign_mask) != '0;
    if (a_neg != b_neg) begin
      a_lt_b = a_neg;
    end else if (a_neg) begin
      a_lt_b = a_mag > b_mag;
    end else begin
      a_lt_b = a_mag < b_mag;
    end

    if (a_nan && b_nan) begin
      return canon_nan;
    end else if (a_nan) begin
      return b;
    end else if (b_nan) begin
      return a;
    end
    return (a_lt_b ^ is_max) ? a : b;
  endfunction

  // ----------------------------------------------------------------------
  // Per-format results
  // ----------------------------------------------------------------------
  logic [SLICE_WIDTH-1:0] fp32_result;
  logic                   fp32_nv;
  logic [SLICE_WIDTH-1:0] fp16_result [NUM_LANES];
  logic [NUM_LANES-1:0]   fp16_nv;

  always_comb begin : compute
    fp32_result = minmax_value(operands_a_i.fp32, operands_b_i.fp32, FP32, op_mod_i, fp32_nv);
    for (int l = 0; l < NUM_LANES; l++) begin
      fp16_result[l] = minmax_value(SLICE_WIDTH'(operands_a_i.fp16[l]),
                                    SLICE_WIDTH'(operands_b_i.fp16[l]),
                                    FP16, op_mod_i, fp16_nv[l]);
    end
  end

  // Lane 0 always runs and upper lanes only for vectorial FP16
  always_comb begin : assemble
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_active_o[l] = (l == 0) || ((fmt_i == FP16) && vectorial_op_i);
      lane_status_o[l] = '0;
    end
    if (fmt_i == FP32) begin
      lane_result_o.fp32          = fp32_result;
      lane_status_o[0][STATUS_NV] = fp32_nv;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        lane_result_o.fp16[l]       = fp16_result[l][FP16_WIDTH-1:0];
        lane_status_o[l][STATUS_NV] = fp16_nv[l] && lane_active_o[l];
      end
    end
  end

endmodule

//--- rtl/slice_pipeline.sv
// Flushable valid/ready register chain
`timescale 1ns/1ps

module slice_pipeline #(
  parameter int unsigned NumPipeRegs = 0
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Upstream handshake
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  // Downstream handshake
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  input  logic                       flush_i,
  output logic                       busy_o,
  // Lane bundle in
  input  fp_slice_pkg::fp_word_u     result_i,
  input  fp_slice_pkg::lane_status_t status_i,
  input  fp_slice_pkg::lane_bits_t   active_i,
  input  fp_slice_pkg::lane_bits_t   mask_i,
  input  fp_slice_pkg::fp_format_e   fmt_i,
  // Lane bundle out
  output fp_slice_pkg::fp_word_u     result_o,
  output fp_slice_pkg::lane_status_t status_o,
  output fp_slice_pkg::lane_bits_t   active_o,
  output fp_slice_pkg::lane_bits_t   mask_o,
  output fp_slice_pkg::fp_format_e   fmt_o
);

  import fp_slice_pkg::*;

  // Index i holds the bundle after i register stages
  logic         valid_q  [0:NumPipeRegs];
  logic         ready    [0:NumPipeRegs];
  fp_word_u     result_q [0:NumPipeRegs];
  lane_status_t status_q [0:NumPipeRegs];
  lane_bits_t   active_q [0:NumPipeRegs];
  lane_bits_t   mask_q   [0:NumPipeRegs];
  fp_format_e   fmt_q    [0:NumPipeRegs];

  // Stage 0 is the producer itself
  assign valid_q[0]  = in_valid_i;
  assign result_q[0] = result_i;
  assign status_q[0] = status_i;
  assign active_q[0] = active_i;
  assign mask_q[0]   = mask_i;
  assign fmt_q[0]    = fmt_i;

  // ----------------------------------------------------------------------
  // Register stages
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic reg_ena;

    // Advance when the next stage moves on or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign reg_ena  = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        result_q[i+1] <= result_q[i];
        status_q[i+1] <= status_q[i];
        active_q[i+1] <= active_q[i];
        mask_q[i+1]   <= mask_q[i];
        fmt_q[i+1]    <= fmt_q[i];
      end
    end
  end

  // Ready ripples back from the consumer
  assign ready[NumPipeRegs] = out_ready_i;
  assign in_ready_o         = ready[0];

  assign out_valid_o = valid_q[NumPipeRegs];
  assign result_o    = result_q[NumPipeRegs];
  assign status_o    = status_q[NumPipeRegs];
  assign active_o    = active_q[NumPipeRegs];
  assign mask_o      = mask_q[NumPipeRegs];
  assign fmt_o       = fmt_q[NumPipeRegs];

  // Any registered stage holding an item
  always_comb begin : busy_flag
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumPipeRegs); i++) begin
      busy_o |= valid_q[i];
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  if (NumPipeRegs > 0) begin : gen_checks
    // A stalled output keeps its whole bundle until taken
    hold_while_stalled: assert property (
      @(posedge clk_i) disable iff (rst_i)
      out_valid_o && !out_ready_i && !flush_i |=>
        out_valid_o && $stable(result_o) && $stable(status_o) &&
        $stable(active_o) && $stable(mask_o) && $stable(fmt_o)
    ) else $error("output bundle changed while stalled");

    // Flushed items never reach the consumer
    flush_empties_output: assert property (
      @(posedge clk_i) disable iff (rst_i)
      flush_i |=> !out_valid_o
    ) else $error("valid output right after flush");
  end

endmodule

//--- rtl/result_packer.sv
// Lane result packer
`timescale 1ns/1ps

module result_packer (
  input  fp_slice_pkg::fp_word_u     result_i,
  input  fp_slice_pkg::lane_status_t status_i,
  input  fp_slice_pkg::lane_bits_t   active_i,
  input  fp_slice_pkg::lane_bits_t   mask_i,
  input  fp_slice_pkg::fp_format_e   fmt_i,
  output fp_slice_pkg::fp_word_u     result_o,
  output fp_slice_pkg::status_t      status_o
);

  import fp_slice_pkg::*;

  // ----------------------------------------------------------------------
  // Result word
  // ----------------------------------------------------------------------

  // FP32 already fills the word
  // FP16 lanes that did not run are NaN-boxed with all ones
  always_comb begin : pack_result
    if (fmt_i == FP32) begin
      result_o = result_i;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (active_i[l]) begin
          result_o.fp16[l] = result_i.fp16[l];
        end else begin
          result_o.fp16[l] = '1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Status
  // ----------------------------------------------------------------------

  // Only lanes enabled by the SIMD mask report flags
  always_comb begin : collapse_status
    status_t merged;

    merged = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      merged |= status_i[l] & {$bits(status_t){mask_i[l]}};
    end
    status_o = merged;
  end

endmodule

//--- rtl/fp_minmax_slice.sv
// FP min/max SIMD slice
`timescale 1ns/1ps

module fp_minmax_slice #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Operation
  input  fp_slice_pkg::fp_word_u   operands_a_i,
  input  fp_slice_pkg::fp_word_u   operands_b_i,
  input  fp_slice_pkg::fp_format_e fmt_i,
  input  logic                     vectorial_op_i,
  input  logic                     op_mod_i,
  input  fp_slice_pkg::lane_bits_t simd_mask_i,
  // Input handshake
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic                     flush_i,
  // Result
  output fp_slice_pkg::fp_word_u   result_o,
  output fp_slice_pkg::status_t    status_o,
  // Output handshake
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  // Items in flight
  output logic                     busy_o
);

  import fp_slice_pkg::*;

  // Producer side bundle
  fp_word_u     lane_result;
  lane_status_t lane_status;
  lane_bits_t   lane_active;

  // Buffer output bundle
  fp_word_u     pipe_result;
  lane_status_t pipe_status;
  lane_bits_t   pipe_active;
  lane_bits_t   pipe_mask;
  fp_format_e   pipe_fmt;

  // ----------------------------------------------------------------------
  // Lane compute, then pipeline, then packing
  // ----------------------------------------------------------------------
  minmax_lanes i_minmax_lanes (
    .operands_a_i   ( operands_a_i   ),
    .operands_b_i   ( operands_b_i   ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .op_mod_i       ( op_mod_i       ),
    .lane_result_o  ( lane_result    ),
    .lane_status_o  ( lane_status    ),
    .lane_active_o  ( lane_active    )
  );

  slice_pipeline #(
    .NumPipeRegs ( NumPipeRegs )
  ) i_slice_pipeline (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .flush_i     ( flush_i     ),
    .busy_o      ( busy_o      ),
    .result_i    ( lane_result ),
    .status_i    ( lane_status ),
    .active_i    ( lane_active ),
    .mask_i      ( simd_mask_i ),
    .fmt_i       ( fmt_i       ),
    .result_o    ( pipe_result ),
    .status_o    ( pipe_status ),
    .active_o    ( pipe_active ),
    .mask_o      ( pipe_mask   ),
    .fmt_o       ( pipe_fmt    )
  );

  result_packer i_result_packer (
    .result_i ( pipe_result ),
    .status_i ( pipe_status ),
    .active_i ( pipe_active ),
    .mask_i   ( pipe_mask   ),
    .fmt_i    ( pipe_fmt    ),
    .result_o ( result_o    ),
    .status_o ( status_o    )
  );

endmodule

//--- test/tb_minmax_model.svh
// Min/max reference model
`ifndef TB_MINMAX_MODEL_SVH
`define TB_MINMAX_MODEL_SVH

// Zeros, ones, quiet and signaling NaNs, infinities
localparam logic [31:0] SPECIAL32 [8] = '{
  32'h0000_0000, 32'h8000_0000, 32'h3f80_0000, 32'hc000_0000,
  32'h7fc0_0001, 32'h7f80_0001, 32'h7f80_0000, 32'hff80_0000
};
localparam logic [15:0] SPECIAL16 [8] = '{
  16'h0000, 16'h8000, 16'h3c00, 16'hc000,
  16'h7e01, 16'h7c01, 16'h7c00, 16'hfc00
};

// Half specials, half random bits
function automatic logic [31:0] pick32();
  return ($urandom_range(1, 0) != 0) ? SPECIAL32[$urandom_range(7, 0)] : $urandom;
endfunction

function automatic logic [15:0] pick16();
  return ($urandom_range(1, 0) != 0) ? SPECIAL16[$urandom_range(7, 0)] : 16'($urandom);
endfunction

// Value of w bits held in the low bits of x
function automatic logic is_nan(input logic [31:0] x, input int w);
  int          man_w;
  logic [31:0] exp_all;

  man_w   = (w == 32) ? 23 : 10;
  exp_all = (32'd1 << (w - 1 - man_w)) - 1;
  return (((x >> man_w) & exp_all) == exp_all) && ((x & ((32'd1 << man_w) - 1)) != 0);
endfunction

function automatic logic is_snan(input logic [31:0] x, input int w);
  int man_w;

  man_w = (w == 32) ? 23 : 10;
  return is_nan(x, w) && !x[man_w-1];
endfunction

// Unsigned key in numeric order, so -0 sits just below +0
function automatic logic [31:0] order_key(input logic [31:0] x, input int w);
  logic [31:0] sign;
  logic [31:0] mask;

  sign = 32'd1 << (w - 1);
  mask = (w == 32) ? 32'hffff_ffff : 32'h0000_ffff;
  return ((x & sign) != 0) ? (~x & mask) : (x | sign);
endfunction

function automatic logic [31:0] ref_minmax(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  int          w,
  input  logic        is_max,
  output logic        snan
);
  snan = is_snan(a, w) || is_snan(b, w);
  if (is_nan(a, w) && is_nan(b, w)) begin
    return (w == 32) ? CANON_NAN_FP32 : 32'(CANON_NAN_FP16);
  end else if (is_nan(a, w)) begin
    return b;
  end else if (is_nan(b, w)) begin
    return a;
  end else if (is_max) begin
    return (order_key(a, w) > order_key(b, w)) ? a : b;
  end
  return (order_key(a, w) < order_key(b, w)) ? a : b;
endfunction

// Expected word and flags of one whole slice operation
function automatic void ref_slice(
  input  fp_word_u   a,
  input  fp_word_u   b,
  input  fp_format_e fmt,
  input  logic       vec,
  input  logic       op_mod,
  input  lane_bits_t mask,
  output fp_word_u   res,
  output status_t    st
);
  logic        nv0;
  logic        nv1;
  logic [31:0] r0;
  logic [31:0] r1;

  st = '0;
  if (fmt == FP32) begin
    res.fp32      = ref_minmax(a.fp32, b.fp32, 32, op_mod, nv0);
    st[STATUS_NV] = nv0 && mask[0];
  end else begin
    r0 = ref_minmax(32'(a.fp16[0]), 32'(b.fp16[0]), 16, op_mod, nv0);
    r1 = ref_minmax(32'(a.fp16[1]), 32'(b.fp16[1]), 16, op_mod, nv1);
    res.fp16[0]   = r0[15:0];
    res.fp16[1]   = vec ? r1[15:0] : 16'hffff;
    st[STATUS_NV] = (nv0 && mask[0]) || (vec && nv1 && mask[1]);
  end
endfunction

`endif

//--- test/tb_fp_minmax_slice.sv
// Min/max slice testbench
`timescale 1ns/1ps

module tb_fp_minmax_slice;

  import fp_slice_pkg::*;

  `include "tb_minmax_model.svh"

  localparam int unsigned NumPipeRegs   = 2;
  localparam int          TimeoutCycles = 200;

  logic       clk_i = 1'b0;
  logic       rst_i;
  fp_word_u   operands_a_i;
  fp_word_u   operands_b_i;
  fp_format_e fmt_i;
  logic       vectorial_op_i;
  logic       op_mod_i;
  lane_bits_t simd_mask_i;
  logic       in_valid_i;
  logic       in_ready_o;
  logic       flush_i;
  fp_word_u   result_o;
  status_t    status_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       busy_o;

  // Expected values in issue order
  fp_word_u   exp_result_q [$];
  status_t    exp_status_q [$];
  // 0 always ready, 1 random stalls and gaps, 2 held off
  int         bp_mode;
  logic       held_valid;
  fp_word_u   held_result;
  status_t    held_status;

  fp_minmax_slice #(
    .NumPipeRegs ( NumPipeRegs )
  ) dut (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .operands_a_i   ( operands_a_i   ),
    .operands_b_i   ( operands_b_i   ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .op_mod_i       ( op_mod_i       ),
    .simd_mask_i    ( simd_mask_i    ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .flush_i        ( flush_i        ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .busy_o         ( busy_o         )
  );

  always #50 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  task automatic fail_with(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, what);
  endtask

  task automatic check_result(input fp_word_u expected, input fp_word_u actual);
    if (actual !== expected) begin
      $display("Fail result_o: expected %08h, actual %08h", expected.fp32, actual.fp32);
      $display("TEST FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_status(input status_t expected, input status_t actual);
    if (actual !== expected) begin
      $display("Fail status_o: expected %02h, actual %02h", expected, actual);
      $display("TEST FAILED");
      $fatal(1, "status mismatch");
    end
  endtask

  // Outputs are settled mid-cycle
  always @(negedge clk_i) begin : monitor
    if (rst_i) begin
      held_valid = 1'b0;
    end else begin
      if (held_valid) begin
        if (!out_valid_o) begin
          fail_with("Output valid dropped while stalled");
        end
        check_result(held_result, result_o);
        check_status(held_status, status_o);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_result_q.size() == 0) begin
          fail_with("Output transfer with no item expected");
        end else begin
          check_result(exp_result_q.pop_front(), result_o);
          check_status(exp_status_q.pop_front(), status_o);
        end
      end
      held_valid  = out_valid_o && !out_ready_i && !flush_i;
      held_result = result_o;
      held_status = status_o;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    case (bp_mode)
      0:       out_ready_i = 1'b1;
      1:       out_ready_i = ($urandom_range(2, 0) != 0);
      default: out_ready_i = 1'b0;
    endcase
  endtask

  task automatic send_op(
    input fp_word_u   a,
    input fp_word_u   b,
    input fp_format_e fmt,
    input logic       vec,
    input logic       op_mod,
    input lane_bits_t mask
  );
    fp_word_u exp_res;
    status_t  exp_st;
    int       waited;

    ref_slice(a, b, fmt, vec, op_mod, mask, exp_res, exp_st);
    operands_a_i   = a;
    operands_b_i   = b;
    fmt_i          = fmt;
    vectorial_op_i = vec;
    op_mod_i       = op_mod;
    simd_mask_i    = mask;
    in_valid_i     = 1'b1;
    waited         = 0;
    @(negedge clk_i);
    while (!in_ready_o && waited <= TimeoutCycles) begin
      waited++;
      next_cycle();
      @(negedge clk_i);
    end
    if (!in_ready_o) begin
      fail_with("Timeout: input was never accepted");
    end else begin
      exp_result_q.push_back(exp_res);
      exp_status_q.push_back(exp_st);
      next_cycle();
      in_valid_i = 1'b0;
      if (bp_mode == 1) begin
        repeat ($urandom_range(2, 0)) next_cycle();
      end
    end
  endtask

  task automatic send_random(input fp_format_e fmt, input logic vec);
    fp_word_u a;
    fp_word_u b;

    if (fmt == FP32) begin
      a.fp32 = pick32();
      b.fp32 = pick32();
    end else begin
      a.fp16[0] = pick16();
      a.fp16[1] = pick16();
      b.fp16[0] = pick16();
      b.fp16[1] = pick16();
    end
    send_op(a, b, fmt, vec, $urandom_range(1, 0), $urandom_range(3, 0));
  endtask

  task automatic drain();
    int waited;

    waited = 0;
    while (exp_result_q.size() != 0 && waited <= TimeoutCycles) begin
      waited++;
      next_cycle();
    end
    if (exp_result_q.size() != 0) begin
      fail_with("Timeout: results still outstanding");
    end
  endtask

  task automatic flush_pipe();
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    flush_i     = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    exp_result_q.delete();
    exp_status_q.delete();
    if (busy_o || out_valid_o) begin
      fail_with("Flush left items in the pipeline");
    end
    out_ready_i = 1'b1;
  endtask

  initial begin : stimulus
    void'($urandom(32'hde6f3bbf));
    rst_i          = 1'b1;
    operands_a_i   = '0;
    operands_b_i   = '0;
    fmt_i          = FP32;
    vectorial_op_i = 1'b0;
    op_mod_i       = 1'b0;
    simd_mask_i    = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b0;
    bp_mode        = 0;
    repeat (2) next_cycle();
    rst_i = 1'b0;
    if (out_valid_o || busy_o || !in_ready_o) begin
      fail_with("Handshake outputs wrong after reset");
    end

    // Ordinary and random values per format
    repeat (40) send_random(FP32, 1'b0);
    repeat (40) send_random(FP16, 1'b0);
    repeat (40) send_random(FP16, 1'b1);

    // Every special pair in both directions
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 8; j++) begin
        for (int m = 0; m < 2; m++) begin
          send_op(SPECIAL32[i], SPECIAL32[j], FP32, 1'b0, m, 2'b01);
          send_op({SPECIAL16[j], SPECIAL16[i]}, {SPECIAL16[i], SPECIAL16[j]},
                  FP16, 1'b1, m, $urandom_range(3, 0));
        end
      end
    end
    drain();

    // Back-pressure and input gaps
    bp_mode = 1;
    repeat (150) send_random(fp_format_e'($urandom_range(1, 0)), $urandom_range(1, 0));
    drain();

    // Flush with items in flight
    bp_mode = 2;
    send_random(FP32, 1'b0);
    send_random(FP16, 1'b1);
    if (!busy_o) begin
      fail_with("No items in flight before flush");
    end
    flush_pipe();
    bp_mode = 0;
    repeat (20) send_random(fp_format_e'($urandom_range(1, 0)), $urandom_range(1, 0));
    drain();
    next_cycle();

    if (busy_o || exp_result_q.size() != 0) begin
      fail_with("Pipeline not empty at end of run");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

//--- project.f
+incdir+test
rtl/fp_slice_pkg.sv
rtl/minmax_lanes.sv
rtl/slice_pipeline.sv
rtl/result_packer.sv
rtl/fp_minmax_slice.sv
test/tb_fp_minmax_slice.sv

//--- Bender.yml
package:
  name: fp_minmax_slice

sources:
  # RTL in dependency order
  - files:
      - rtl/fp_slice_pkg.sv
      - rtl/minmax_lanes.sv
      - rtl/slice_pipeline.sv
      - rtl/result_packer.sv
      - rtl/fp_minmax_slice.sv

  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_fp_minmax_slice.sv
